//--- common/iq_pkg.sv
`default_nettype none

package iq_pkg;

    // --------------------
    // Fixed field widths
    // --------------------
    localparam int op_bits    = 6;   // Opcode, passed through untouched
    localparam int imm_bits   = 32;
    localparam int shift_bits = 5;

    // Single-bit fields: has_imm, src1_ready, src2_ready, regwrite, memwrite, memread
    localparam int flag_bits = 6;

    // The two lowest fields do not depend on the tag width
    localparam int memread_pos  = 0;
    localparam int memwrite_pos = 1;
    localparam int dest_lsb     = 2;

    // --------------------
    // Width helpers
    // --------------------
    function automatic int tag_bits(input int num_phys_regs);
        return $clog2(num_phys_regs);
    endfunction

    // Fixed fields plus the src1, src2 and dest tags
    function automatic int iq_entry_bits(input int num_phys_regs);
        return op_bits + imm_bits + shift_bits + flag_bits + 3 * tag_bits(num_phys_regs);
    endfunction

    // --------------------
    // Field positions, counted up from memread at bit 0
    // --------------------
    function automatic int regwrite_pos(input int tag_w);
        return dest_lsb + tag_w;
    endfunction

    function automatic int shift_lsb(input int tag_w);
        return regwrite_pos(tag_w) + 1;
    endfunction

    function automatic int src2_ready_pos(input int tag_w);
        return shift_lsb(tag_w) + shift_bits;
    endfunction

    function automatic int src2_lsb(input int tag_w);
        return src2_ready_pos(tag_w) + 1;
    endfunction

    function automatic int src1_ready_pos(input int tag_w);
        return src2_lsb(tag_w) + tag_w;
    endfunction

    function automatic int src1_lsb(input int tag_w);
        return src1_ready_pos(tag_w) + 1;
    endfunction

endpackage

`default_nettype wire

//--- issue_queue/iq_slot.sv
`timescale 1ns/1ps
`default_nettype none

module iq_slot #(
    parameter int NUM_PHYS_REGS = 64,
    parameter int QUEUE_SIZE    = 16
) (
    input  wire logic                                          CLK,
    input  wire logic                                          RESET,
    input  wire logic                                          write,     // Allocate this slot
    input  wire logic                                          clear,     // Issued, free the slot
    input  wire logic                                          age_tick,  // Some enqueue accepted
    input  wire logic [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0] entry_in,
    input  wire logic                                          ready_update,
    input  wire logic [$clog2(NUM_PHYS_REGS)-1:0]              ready_register,
    output logic                                               valid,
    output logic                                               ready,
    output logic [$clog2(QUEUE_SIZE):0]                        age,
    output logic [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0]    entry
);
    import iq_pkg::*;

    localparam int ENTRY_BITS = iq_entry_bits(NUM_PHYS_REGS);
    localparam int TAG_BITS   = tag_bits(NUM_PHYS_REGS);
    localparam int AGE_BITS   = $clog2(QUEUE_SIZE) + 1;
    localparam int S1_RDY     = src1_ready_pos(TAG_BITS);
    localparam int S2_RDY     = src2_ready_pos(TAG_BITS);
    localparam int S1_LSB     = src1_lsb(TAG_BITS);
    localparam int S2_LSB     = src2_lsb(TAG_BITS);

    localparam logic [AGE_BITS-1:0] AGE_MAX = AGE_BITS'(QUEUE_SIZE);

    logic [ENTRY_BITS-1:0] entry_q;
    logic                  valid_q;
    logic                  src1_rdy_q;
    logic                  src2_rdy_q;
    logic [AGE_BITS-1:0]   age_q;

    logic src1_now;
    logic src2_now;
    logic in_src1_rdy;
    logic in_src2_rdy;

    // --------------------
    // Wakeup
    // --------------------
    // A stored source is ready by its flag or by a tag hit this cycle
    assign src1_now = src1_rdy_q |
                      (ready_update && entry_q[S1_LSB +: TAG_BITS] == ready_register);
    assign src2_now = src2_rdy_q |
                      (ready_update && entry_q[S2_LSB +: TAG_BITS] == ready_register);

    // An entry arriving alongside a matching broadcast must not miss it
    assign in_src1_rdy = entry_in[S1_RDY] |
                         (ready_update && entry_in[S1_LSB +: TAG_BITS] == ready_register);
    assign in_src2_rdy = entry_in[S2_RDY] |
                         (ready_update && entry_in[S2_LSB +: TAG_BITS] == ready_register);

    // --------------------
    // Slot state
    // --------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid_q    <= 1'b0;
            src1_rdy_q <= 1'b0;
            src2_rdy_q <= 1'b0;
            age_q      <= '0;
        end else if (write) begin
            valid_q    <= 1'b1;
            src1_rdy_q <= in_src1_rdy;
            src2_rdy_q <= in_src2_rdy;
            age_q      <= '0;       // Youngest entry in the queue
        end else if (clear) begin
            valid_q <= 1'b0;
        end else if (valid_q) begin
            src1_rdy_q <= src1_now;
            src2_rdy_q <= src2_now;
            if (age_tick && age_q != AGE_MAX) begin
                age_q <= age_q + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (write) begin
            entry_q <= entry_in;
        end
    end

    // Stored entry with the live ready flags patched in
    always_comb begin
        entry         = entry_q;
        entry[S1_RDY] = src1_now;
        entry[S2_RDY] = src2_now;
    end

    assign valid = valid_q;
    assign ready = valid_q & src1_now & src2_now;
    assign age   = age_q;

endmodule

`default_nettype wire

//--- issue_queue/iq_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module iq_alloc #(
    parameter int QUEUE_SIZE = 16
) (
    input  wire logic                  CLK,
    input  wire logic                  RESET,
    input  wire logic                  enqueue,
    input  wire logic [QUEUE_SIZE-1:0] slot_valid,
    output logic      [QUEUE_SIZE-1:0] slot_write,
    output logic                       age_tick,
    output logic                       full,
    output logic                       enqueue_result
);

    logic [QUEUE_SIZE-1:0] lowest_free;
    logic                  enq_result_q;

    // --------------------
    // Free slot search
    // --------------------
    // Adding one to the valid vector carries through the low run of ones
    // and stops at the first zero, so ANDing with the inverse leaves only
    // the lowest free slot set. A full queue wraps to zero and picks nothing
    assign lowest_free = ~slot_valid & (slot_valid + 1'b1);

    assign full = &slot_valid;  // Registered valids only, so this reflects the last edge

    // Acceptance also ages every stored entry by one
    assign age_tick   = enqueue & ~full;
    assign slot_write = age_tick ? lowest_free : '0;

    // --------------------
    // Result pulse
    // --------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            enq_result_q <= 1'b0;
        end else begin
            enq_result_q <= age_tick;   // One cycle high per accepted enqueue
        end
    end

    assign enqueue_result = enq_result_q;

endmodule

`default_nettype wire

//--- issue_queue/iq_select.sv
`timescale 1ns/1ps
`default_nettype none

module iq_select #(
    parameter int NUM_PHYS_REGS = 64,
    parameter int QUEUE_SIZE    = 16
) (
    input  wire logic                                                     CLK,
    input  wire logic                                                     RESET,
    input  wire logic                                                     dequeue,
    input  wire logic [QUEUE_SIZE-1:0]                                    slot_ready,
    input  wire logic [QUEUE_SIZE*($clog2(QUEUE_SIZE)+1)-1:0]             slot_age,
    input  wire logic [QUEUE_SIZE*iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0] slot_entry,
    output logic      [QUEUE_SIZE-1:0]                                    slot_clear,
    output logic                                                          dequeue_result,
    output logic      [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0]          entry_out
);
    import iq_pkg::*;

    localparam int ENTRY_BITS = iq_entry_bits(NUM_PHYS_REGS);
    localparam int AGE_BITS   = $clog2(QUEUE_SIZE) + 1;
    localparam int IDX_BITS   = $clog2(QUEUE_SIZE);
    localparam int LEAVES     = 1 << IDX_BITS;  // Tree padded up to a power of two
    localparam int NODES      = 2 * LEAVES - 1;

    // Node n has children 2n+1 and 2n+2, the leaves sit at LEAVES-1 and up
    logic                node_vld [NODES];
    logic [AGE_BITS-1:0] node_age [NODES];
    logic [IDX_BITS-1:0] node_idx [NODES];

    logic                take;
    logic [IDX_BITS-1:0] oldest_idx;

    // --------------------
    // Leaves
    // --------------------
    for (genvar l = 0; l < LEAVES; l++) begin : g_leaf
        if (l < QUEUE_SIZE) begin : g_slot
            assign node_vld[LEAVES-1+l] = slot_ready[l];
            assign node_age[LEAVES-1+l] = slot_age[l*AGE_BITS +: AGE_BITS];
            assign node_idx[LEAVES-1+l] = IDX_BITS'(l);
        end else begin : g_pad
            assign node_vld[LEAVES-1+l] = 1'b0;     // Never wins
            assign node_age[LEAVES-1+l] = '0;
            assign node_idx[LEAVES-1+l] = '0;
        end
    end

    // --------------------
    // Comparison tree
    // --------------------
    for (genvar n = 0; n < LEAVES - 1; n++) begin : g_node
        logic pick_right;

        // Left side keeps an equal age, so ties go to the lower slot index
        assign pick_right = node_vld[2*n+2] &&
                            (!node_vld[2*n+1] || node_age[2*n+2] > node_age[2*n+1]);

        assign node_vld[n] = node_vld[2*n+1] | node_vld[2*n+2];
        assign node_age[n] = pick_right ? node_age[2*n+2] : node_age[2*n+1];
        assign node_idx[n] = pick_right ? node_idx[2*n+2] : node_idx[2*n+1];
    end

    assign oldest_idx = node_idx[0];
    assign take       = dequeue & node_vld[0];    // Nothing ready means no issue

    assign slot_clear = take ? (QUEUE_SIZE'(1) << oldest_idx) : '0;

    // --------------------
    // Issue registers
    // --------------------
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            dequeue_result <= 1'b0;
            entry_out      <= '0;
        end else begin
            dequeue_result <= take;
            if (take) begin
                entry_out <= slot_entry[oldest_idx*ENTRY_BITS +: ENTRY_BITS];  // Held until next issue
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/issue_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module issue_queue_top #(
    parameter int NUM_PHYS_REGS = 64,
    parameter int QUEUE_SIZE    = 16
) (
    input  wire logic                                          CLK,
    input  wire logic                                          RESET,
    input  wire logic                                          enqueue,
    input  wire logic [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0] entry_in,
    input  wire logic                                          ready_update,
    input  wire logic [$clog2(NUM_PHYS_REGS)-1:0]              ready_register,
    input  wire logic                                          dequeue,
    output logic                                               enqueue_result,
    output logic                                               dequeue_result,
    output logic                                               full,
    output logic [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0]    entry_out
);
    import iq_pkg::*;

    localparam int ENTRY_BITS = iq_entry_bits(NUM_PHYS_REGS);
    localparam int AGE_BITS   = $clog2(QUEUE_SIZE) + 1;

    logic [QUEUE_SIZE-1:0]            slot_valid;
    logic [QUEUE_SIZE-1:0]            slot_ready;
    logic [QUEUE_SIZE-1:0]            slot_write;
    logic [QUEUE_SIZE-1:0]            slot_clear;
    logic [QUEUE_SIZE*AGE_BITS-1:0]   slot_age;     // Slot i at bits i*AGE_BITS and up
    logic [QUEUE_SIZE*ENTRY_BITS-1:0] slot_entry;
    logic                             age_tick;

    // --------------------
    // Allocation
    // --------------------
    iq_alloc #(
        .QUEUE_SIZE     (QUEUE_SIZE)
    ) iq_alloc_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .enqueue        (enqueue),
        .slot_valid     (slot_valid),
        .slot_write     (slot_write),
        .age_tick       (age_tick),
        .full           (full),
        .enqueue_result (enqueue_result)
    );

    // --------------------
    // Slot array
    // --------------------
    for (genvar i = 0; i < QUEUE_SIZE; i++) begin : g_slot
        iq_slot #(
            .NUM_PHYS_REGS  (NUM_PHYS_REGS),
            .QUEUE_SIZE     (QUEUE_SIZE)
        ) iq_slot_inst (
            .CLK            (CLK),
            .RESET          (RESET),
            .write          (slot_write[i]),
            .clear          (slot_clear[i]),
            .age_tick       (age_tick),
            .entry_in       (entry_in),
            .ready_update   (ready_update),
            .ready_register (ready_register),
            .valid          (slot_valid[i]),
            .ready          (slot_ready[i]),
            .age            (slot_age[i*AGE_BITS +: AGE_BITS]),
            .entry          (slot_entry[i*ENTRY_BITS +: ENTRY_BITS])
        );
    end

    // Selection sees the same-cycle wakeups through slot_ready
    iq_select #(
        .NUM_PHYS_REGS  (NUM_PHYS_REGS),
        .QUEUE_SIZE     (QUEUE_SIZE)
    ) iq_select_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .dequeue        (dequeue),
        .slot_ready     (slot_ready),
        .slot_age       (slot_age),
        .slot_entry     (slot_entry),
        .slot_clear     (slot_clear),
        .dequeue_result (dequeue_result),
        .entry_out      (entry_out)
    );

endmodule

`default_nettype wire

//--- verif/iq_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module iq_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 16
) (
    output logic CLK,
    output logic RESET
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        RESET = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);     // Release away from the rising edge
        RESET = 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/iq_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module iq_monitor #(
    parameter int NUM_PHYS_REGS = 64
) (
    input  wire logic                                          CLK,
    input  wire logic                                          RESET,
    input  wire logic                                          enqueue_result,
    input  wire logic                                          dequeue_result,
    input  wire logic                                          full,
    input  wire logic [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0] entry_out,
    input  wire logic                                          exp_valid,
    input  wire logic                                          exp_enqueue_result,
    input  wire logic                                          exp_dequeue_result,
    input  wire logic                                          exp_full,
    input  wire logic [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0] exp_entry_out,
    output int                                                 error_count
);
    import iq_pkg::*;

    localparam int ENTRY_BITS = iq_entry_bits(NUM_PHYS_REGS);

    // Expected values arrive with the stimulus, one cycle ahead of the DUT
    logic                  valid_d;
    logic                  enq_d;
    logic                  deq_d;
    logic                  full_d;
    logic [ENTRY_BITS-1:0] entry_d;
    int                    errors = 0;

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            valid_d <= 1'b0;
            enq_d   <= 1'b0;
            deq_d   <= 1'b0;
            full_d  <= 1'b0;
            entry_d <= '0;
        end else begin
            valid_d <= exp_valid;
            enq_d   <= exp_enqueue_result;
            deq_d   <= exp_dequeue_result;
            full_d  <= exp_full;
            entry_d <= exp_entry_out;
        end
    end

    task automatic compare(input string name, input logic [ENTRY_BITS-1:0] expected,
                           input logic [ENTRY_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge CLK) begin
        if (valid_d) begin
            compare("enqueue_result", ENTRY_BITS'(enq_d), ENTRY_BITS'(enqueue_result));
            compare("dequeue_result", ENTRY_BITS'(deq_d), ENTRY_BITS'(dequeue_result));
            compare("full", ENTRY_BITS'(full_d), ENTRY_BITS'(full));
            compare("entry_out", entry_d, entry_out);
        end
    end

    assign error_count = errors;

endmodule

`default_nettype wire

//--- verif/iq_checker.sv
`timescale 1ns/1ps
`default_nettype none

module iq_checker #(
    parameter int NUM_PHYS_REGS = 64
) (
    input wire logic                                          CLK,
    input wire logic                                          RESET,
    input wire logic                                          enqueue,
    input wire logic                                          dequeue,
    input wire logic                                          enqueue_result,
    input wire logic                                          dequeue_result,
    input wire logic                                          full,
    input wire logic [iq_pkg::iq_entry_bits(NUM_PHYS_REGS)-1:0] entry_out
);

    int failures = 0;   // Summed into the testbench error count

    // A refused enqueue leaves no result pulse behind
    assert property (@(posedge CLK) disable iff (!RESET) full |=> !enqueue_result)
        else begin
            failures++;
            $error("enqueue_result followed a cycle with full high");
        end

    // Back-to-back pulses need a strobe behind each of them
    assert property (@(posedge CLK) disable iff (!RESET)
        (enqueue_result && $past(enqueue_result)) |-> ($past(enqueue) && $past(enqueue, 2)))
        else begin
            failures++;
            $error("enqueue_result high two cycles in a row without two enqueues");
        end

    assert property (@(posedge CLK) disable iff (!RESET)
        (dequeue_result && $past(dequeue_result)) |-> ($past(dequeue) && $past(dequeue, 2)))
        else begin
            failures++;
            $error("dequeue_result high two cycles in a row without two dequeues");
        end

    assert property (@(posedge CLK) $rose(RESET) |->
        (!enqueue_result && !dequeue_result && !full && entry_out == '0))
        else begin
            failures++;
            $error("outputs not cleared in the first cycle after reset");
        end

endmodule

bind issue_queue_top iq_checker #(
    .NUM_PHYS_REGS  (NUM_PHYS_REGS)
) iq_checker_inst (
    .CLK            (CLK),
    .RESET          (RESET),
    .enqueue        (enqueue),
    .dequeue        (dequeue),
    .enqueue_result (enqueue_result),
    .dequeue_result (dequeue_result),
    .full           (full),
    .entry_out      (entry_out)
);

`default_nettype wire

//--- verif/iq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iq_tb;
    import iq_pkg::*;

    localparam int NPR    = 64;
    localparam int QSIZE  = 8;
    localparam int EW     = iq_entry_bits(NPR);
    localparam int TW     = tag_bits(NPR);
    localparam int S1_RDY = src1_ready_pos(TW);
    localparam int S2_RDY = src2_ready_pos(TW);
    localparam int S1_LSB = src1_lsb(TW);
    localparam int S2_LSB = src2_lsb(TW);

    // Fill, drain, wakeup, skip and random mix, each with two settling cycles
    localparam int TEST_CYCLES = 11 + 10 + 13 + 6 + 302;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 16;

    logic          CLK;
    logic          RESET;
    logic          enqueue;
    logic          ready_update;
    logic          dequeue;
    logic [EW-1:0] entry_in;
    logic [TW-1:0] ready_register;
    logic          enqueue_result;
    logic          dequeue_result;
    logic          full;
    logic [EW-1:0] entry_out;

    logic          exp_valid = 1'b0;
    logic          exp_enq   = 1'b0;
    logic          exp_deq   = 1'b0;
    logic          exp_full  = 1'b0;
    logic [EW-1:0] exp_entry = '0;

    // --------------------
    // Reference model, oldest entry first
    // --------------------
    logic [EW-1:0] ref_entry[$];
    int            ref_count[$];    // Accepted enqueues since arrival
    logic          m_enq;
    logic          m_deq;
    logic          m_full;
    logic [EW-1:0] m_entry = '0;    // Held like entry_out

    int unsigned lcg_state    = 9794;
    int          cycle_count  = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          errors_seen  = 0;
    int          monitor_errors;

    iq_clock_gen #(.PERIOD(100), .RESET_CYCLES(16)) iq_clock_gen_inst (
        .CLK   (CLK),
        .RESET (RESET)
    );

    issue_queue_top #(.NUM_PHYS_REGS(NPR), .QUEUE_SIZE(QSIZE)) issue_queue_top_inst (
        .CLK            (CLK),
        .RESET          (RESET),
        .enqueue        (enqueue),
        .entry_in       (entry_in),
        .ready_update   (ready_update),
        .ready_register (ready_register),
        .dequeue        (dequeue),
        .enqueue_result (enqueue_result),
        .dequeue_result (dequeue_result),
        .full           (full),
        .entry_out      (entry_out)
    );

    iq_monitor #(.NUM_PHYS_REGS(NPR)) iq_monitor_inst (
        .CLK                (CLK),
        .RESET              (RESET),
        .enqueue_result     (enqueue_result),
        .dequeue_result     (dequeue_result),
        .full               (full),
        .entry_out          (entry_out),
        .exp_valid          (exp_valid),
        .exp_enqueue_result (exp_enq),
        .exp_dequeue_result (exp_deq),
        .exp_full           (exp_full),
        .exp_entry_out      (exp_entry),
        .error_count        (monitor_errors)
    );

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Random payload with the source fields set by the caller
    function automatic logic [EW-1:0] make_entry(input logic [TW-1:0] t1, input logic r1,
                                                 input logic [TW-1:0] t2, input logic r2);
        logic [79:0] bits;
        bits = {lcg_next(), lcg_next(), lcg_next(), lcg_next(), lcg_next()};
        make_entry = bits[EW-1:0];
        make_entry[S1_LSB +: TW] = t1;
        make_entry[S1_RDY]       = r1;
        make_entry[S2_LSB +: TW] = t2;
        make_entry[S2_RDY]       = r2;
    endfunction

    function automatic logic [EW-1:0] wake(input logic [EW-1:0] e, input logic upd,
                                           input logic [TW-1:0] tag);
        if (upd && e[S1_LSB +: TW] == tag) begin
            e[S1_RDY] = 1'b1;
        end
        if (upd && e[S2_LSB +: TW] == tag) begin
            e[S2_RDY] = 1'b1;
        end
        return e;
    endfunction

    // One cycle of the queue: wakeup, then oldest-ready select, then enqueue
    function automatic void model_step(input logic enq, input logic [EW-1:0] ent,
                                       input logic upd, input logic [TW-1:0] tag,
                                       input logic deq);
        int  pick;
        bit  was_full;
        was_full = ref_entry.size() >= QSIZE;
        pick     = -1;
        foreach (ref_entry[k]) begin
            ref_entry[k] = wake(ref_entry[k], upd, tag);
            if (pick < 0 && ref_entry[k][S1_RDY] && ref_entry[k][S2_RDY]) begin
                pick = k;
            end
        end
        m_deq = deq && pick >= 0;
        if (m_deq) begin
            m_entry = ref_entry[pick];
            ref_entry.delete(pick);
            ref_count.delete(pick);
        end
        m_enq = enq && !was_full;
        if (m_enq) begin
            foreach (ref_count[k]) begin
                ref_count[k]++;
            end
            ref_entry.push_back(wake(ent, upd, tag));
            ref_count.push_back(0);
        end
        m_full = ref_entry.size() >= QSIZE;
    endfunction

    task automatic step(input logic enq, input logic [EW-1:0] ent, input logic upd,
                        input logic [TW-1:0] tag, input logic deq);
        @(posedge CLK);
        enqueue        <= enq;
        entry_in       <= ent;
        ready_update   <= upd;
        ready_register <= tag;
        dequeue        <= deq;
        model_step(enq, ent, upd, tag, deq);
        exp_valid <= 1'b1;
        exp_enq   <= m_enq;
        exp_deq   <= m_deq;
        exp_full  <= m_full;
        exp_entry <= m_entry;
    endtask

    function automatic int error_sum();
        return monitor_errors + issue_queue_top_inst.iq_checker_inst.failures;
    endfunction

    task automatic end_test(input string name);
        int errs;
        repeat (2) step(1'b0, '0, 1'b0, '0, 1'b0);  // Let the last results be compared
        @(negedge CLK);     // Assertions on the last results have run by now
        errs = error_sum() - errors_seen;
        errors_seen += errs;
        if (errs == 0) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errs);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    initial begin
        logic          enq;
        logic          deq;
        logic          upd;
        logic          r1;
        logic          r2;
        logic [TW-1:0] tag;
        logic [TW-1:0] t1;
        logic [TW-1:0] t2;
        enqueue        = 1'b0;
        entry_in       = '0;
        ready_update   = 1'b0;
        ready_register = '0;
        dequeue        = 1'b0;
        wait (RESET === 1'b1);

        for (int i = 0; i < QSIZE + 1; i++) begin  // Last one meets a full queue
            step(1'b1, make_entry(TW'(lcg_next()), 1'b1, TW'(lcg_next()), 1'b1), 1'b0, '0, 1'b0);
        end
        end_test("fill_and_refuse");

        for (int i = 0; i < QSIZE; i++) begin
            step(1'b0, '0, 1'b0, '0, 1'b1);
        end
        end_test("oldest_first");

        // Entries 0 and 2 also wait on src2
        for (int i = 0; i < 4; i++) begin
            step(1'b1, make_entry(TW'(20 + i), 1'b0, TW'(30 + i), 1'(i % 2)), 1'b0, '0, 1'b0);
        end
        step(1'b0, '0, 1'b0, '0, 1'b1);
        step(1'b0, '0, 1'b1, TW'(30), 1'b1);
        step(1'b0, '0, 1'b1, TW'(32), 1'b0);
        for (int i = 0; i < 4; i++) begin
            step(1'b0, '0, 1'b1, TW'(20 + i), 1'b1);     // Wake and issue in one cycle
        end
        end_test("wakeup");

        step(1'b1, make_entry(TW'(40), 1'b0, TW'(41), 1'b1), 1'b0, '0, 1'b0);
        step(1'b1, make_entry(TW'(42), 1'b1, TW'(43), 1'b1), 1'b0, '0, 1'b0);
        step(1'b0, '0, 1'b0, '0, 1'b1);
        step(1'b0, '0, 1'b1, TW'(40), 1'b1);
        end_test("skip_not_ready");

        for (int i = 0; i < 300; i++) begin
            enq = (lcg_next() % 100) < 55;
            deq = (lcg_next() % 100) < 45;
            upd = (lcg_next() % 100) < 50;
            tag = TW'(lcg_next() % 16);
            t1  = TW'(lcg_next() % 16);
            r1  = 1'(lcg_next() % 2);
            t2  = TW'(lcg_next() % 16);
            r2  = 1'(lcg_next() % 2);
            // Hold off enqueues that would saturate the oldest age, and drain it instead
            if (enq && ref_entry.size() > 0 && ref_entry.size() < QSIZE &&
                ref_count[0] >= QSIZE - 1) begin
                enq = 1'b0;
                deq = 1'b1;
                upd = 1'b1;
                tag = ref_entry[0][S1_RDY] ? ref_entry[0][S2_LSB +: TW]
                                           : ref_entry[0][S1_LSB +: TW];
            end
            step(enq, make_entry(t1, r1, t2, r2), upd, tag, deq);
        end
        end_test("random_mix");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_sum() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
common/iq_pkg.sv
issue_queue/iq_slot.sv
issue_queue/iq_alloc.sv
issue_queue/iq_select.sv
verilog/issue_queue_top.sv
verif/iq_clock_gen.sv
verif/iq_monitor.sv
verif/iq_checker.sv
verif/iq_tb.sv
